/* arm_core.f */
verilog/arm_pkg.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/arm_core.sv
bench/arm_checker.sv
bench/arm_core_assert.sv
bench/tb_arm_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_arm_core
FILELIST  ?= arm_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_arm_core.sv */
`default_nettype none

module tb_arm_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_rows = 18;
  localparam logic [31:0] halt_word = {4'he, 3'b101, 1'b0, 24'hff_fffe};

  logic        clk;
  logic        nreset;
  logic        run;
  logic        imem_we;
  logic [3:0]  imem_addr;
  logic [31:0] imem_data;
  wire         wb_valid;
  wire  [3:0]  wb_reg;
  wire  [31:0] wb_data;
  wire         st_valid;
  wire  [2:0]  st_addr;
  wire  [31:0] st_data;

  // program table with immediates patched from the lcg
  logic [31:0] tbl_code [num_rows][16];
  int          tbl_len  [num_rows];
  logic [15:0] tbl_imm  [num_rows];
  logic [15:0] tbl_flip [num_rows];
  logic [31:0] code [16];
  int          code_len;
  logic [31:0] lcg_state;
  int          timeouts;
  int          total;

  arm_core DUT (
    .clk(clk), .nreset(nreset), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
  );

  arm_checker u_check (
    .clk(clk), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // instruction encoders

  function automatic logic [31:0] dp_word(input logic [3:0] cond, input logic i,
                                          input logic [3:0] op, input logic s,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [11:0] operand);
    return {cond, 2'b00, i, op, s, rn, rd, operand};
  endfunction

  // pre-indexed with the offset added
  function automatic logic [31:0] ls_word(input logic l, input logic [3:0] rn,
                                          input logic [3:0] rd, input logic [11:0] off);
    return {4'he, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, l, rn, rd, off};
  endfunction

  function automatic logic [31:0] br_word(input logic [3:0] cond, input logic link,
                                          input logic [23:0] off);
    return {cond, 3'b101, link, off};
  endfunction

  function automatic logic [31:0] bx_word(input logic [3:0] rm);
    return {4'he, 24'h12_fff1, rm};
  endfunction

  task automatic build_table();
    int c;
    int row;
    // and .. rsc on r1, r2
    // sub sets the flags so the carry into adc .. rsc varies
    for (c = 0; c < 8; c++) begin
      tbl_code[0][c + 2] = dp_word(4'he, 1'b0, 4'(c), (c == 2), 4'd1, 4'(c + 3), 12'h002);
      tbl_code[1][c + 2] = dp_word(4'he, 1'b0, 4'(c + 8), 1'b0, 4'd1, 4'(c + 3), 12'h002);
    end
    for (row = 0; row < 2; row++) begin
      tbl_code[row][0]  = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd1, 12'h0);
      tbl_code[row][1]  = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd2, 12'h0);
      // add into r15 is dropped by decode
      tbl_code[row][10] = dp_word(4'he, 1'b0, arm_pkg::op_add, 1'b0, 4'd1, 4'd15, 12'h002);
      tbl_code[row][11] = halt_word;
      tbl_len[row]  = 12;
      tbl_imm[row]  = 16'h0003;
      tbl_flip[row] = 16'h0003;
    end
    // one row per condition code from eq to le
    for (c = 0; c < 14; c++) begin
      row = c + 2;
      tbl_code[row][0] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd1, 12'h0);
      tbl_code[row][1] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd2, 12'h0);
      tbl_code[row][2] = dp_word(4'he, 1'b0, arm_pkg::op_cmp, 1'b1, 4'd1, 4'd0,
                                 (c % 4 == 3) ? 12'h001 : 12'h002);
      tbl_code[row][3] = br_word(4'(c), 1'b0, 24'h0);
      tbl_code[row][4] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd3, 12'h0);
      tbl_code[row][5] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd4, 12'h0);
      tbl_code[row][6] = halt_word;
      tbl_len[row]  = 7;
      tbl_imm[row]  = 16'h0033;
      tbl_flip[row] = 16'h0003;
    end
    // call and return
    tbl_code[16][0] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd1, 12'h0);
    tbl_code[16][1] = br_word(4'he, 1'b1, 24'h00_0001);
    tbl_code[16][2] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd2, 12'h0);
    tbl_code[16][3] = halt_word;
    tbl_code[16][4] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd3, 12'h0);
    tbl_code[16][5] = bx_word(4'd14);
    tbl_len[16]  = 6;
    tbl_imm[16]  = 16'h0015;
    tbl_flip[16] = 16'h0000;
    // store then load back
    tbl_code[17][0] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd1, 12'h0);
    tbl_code[17][1] = dp_word(4'he, 1'b1, arm_pkg::op_mov, 1'b0, 4'd0, 4'd2, 12'h0);
    tbl_code[17][2] = ls_word(1'b0, 4'd1, 4'd2, 12'h00c);
    tbl_code[17][3] = ls_word(1'b1, 4'd1, 4'd5, 12'h00c);
    tbl_code[17][4] = dp_word(4'he, 1'b1, arm_pkg::op_mvn, 1'b0, 4'd0, 4'd6, 12'h0);
    tbl_code[17][5] = ls_word(1'b0, 4'd1, 4'd6, 12'h010);
    tbl_code[17][6] = ls_word(1'b1, 4'd1, 4'd7, 12'h010);
    tbl_code[17][7] = halt_word;
    tbl_len[17]  = 8;
    tbl_imm[17]  = 16'h0013;
    tbl_flip[17] = 16'h0002;
  endtask

  // random low byte and a coin flip that turns mov into mvn
  task automatic fill_row(input int row);
    logic [31:0] rnd;
    int k;
    code_len = tbl_len[row];
    for (k = 0; k < code_len; k++) begin
      code[k] = tbl_code[row][k];
      if (tbl_imm[row][k]) begin
        rnd = lcg_next();
        code[k][7:0] = rnd[23:16];
        if (tbl_flip[row][k] && rnd[27]) begin
          code[k][22] = 1'b1;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model of the instruction rules

  function automatic logic cond_ok(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'ha: return n == v;
      4'hb: return n != v;
      4'hc: return !z && (n == v);
      4'hd: return z || (n != v);
      4'he: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void add_model(input logic [31:0] x, input logic [31:0] y,
                                    input logic ci, output logic [31:0] res,
                                    output logic c, output logic v);
    {c, res} = {1'b0, x} + {1'b0, y} + 33'(ci);
    v = (x[31] == y[31]) && (res[31] != x[31]);
  endfunction

  // x - y - borrow where carry means no borrow
  function automatic void sub_model(input logic [31:0] x, input logic [31:0] y,
                                    input logic bo, output logic [31:0] res,
                                    output logic c, output logic v);
    res = x - y - 32'(bo);
    c = {1'b0, x} >= ({1'b0, y} + 33'(bo));
    v = (x[31] != y[31]) && (res[31] != x[31]);
  endfunction

  function automatic void alu_model(input logic [3:0] op, input logic [31:0] a,
                                    input logic [31:0] b, input logic cin,
                                    output logic [31:0] res, output logic c,
                                    output logic v, output logic arith);
    c = 1'b0;
    v = 1'b0;
    arith = 1'b1;
    case (op)
      4'h2, 4'ha: sub_model(a, b, 1'b0, res, c, v);
      4'h3:       sub_model(b, a, 1'b0, res, c, v);
      4'h4, 4'hb: add_model(a, b, 1'b0, res, c, v);
      4'h5:       add_model(a, b, cin, res, c, v);
      4'h6:       sub_model(a, b, !cin, res, c, v);
      4'h7:       sub_model(b, a, !cin, res, c, v);
      default: begin
        arith = 1'b0;
        case (op)
          4'h0, 4'h8: res = a & b;
          4'h1, 4'h9: res = a ^ b;
          4'hc:       res = a | b;
          4'hd:       res = b;
          4'he:       res = a & ~b;
          default:    res = ~b;
        endcase
      end
    endcase
  endfunction

  task automatic run_model();
    logic [31:0] r [16];
    logic [31:0] mem [8];
    logic [3:0]  f;
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        c;
    logic        v;
    logic        arith;
    logic        halted;
    int          steps;
    for (steps = 0; steps < 16; steps++) begin
      r[steps] = '0;
    end
    f = 4'h0;
    pc = '0;
    halted = 1'b0;
    for (steps = 0; steps < 64 && !halted; steps++) begin
      w = code[pc[5:2]];
      r[15] = pc + 32'd8;
      if (w[27:4] == 24'h12_fff1) begin
        pc = cond_ok(w[31:28], f) ? {r[w[3:0]][31:2], 2'b00} : pc + 32'd4;
      end else if (w[27:25] == 3'b101) begin
        if (cond_ok(w[31:28], f)) begin
          if (w[24]) begin
            r[14] = pc + 32'd4;
            u_check.expect_retire(4'd14, pc + 32'd4);
          end
          a = pc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
          halted = (a == pc);
          pc = a;
        end else begin
          pc = pc + 32'd4;
        end
      end else if (w[27:26] == 2'b01) begin
        a = r[w[19:16]] + {20'b0, w[11:0]};
        if (w[20]) begin
          r[w[15:12]] = mem[a[4:2]];
          u_check.expect_retire(w[15:12], mem[a[4:2]]);
        end else begin
          mem[a[4:2]] = r[w[15:12]];
          u_check.expect_store(a[4:2], r[w[15:12]]);
        end
        pc = pc + 32'd4;
      end else begin
        a = r[w[19:16]];
        b = w[25] ? {24'b0, w[7:0]} : r[w[3:0]];
        // only flag-setting ops are conditional
        if (!w[20] || cond_ok(w[31:28], f)) begin
          alu_model(w[24:21], a, b, f[1], res, c, v, arith);
          if (w[24:23] != 2'b10 && w[15:12] != 4'd15) begin
            r[w[15:12]] = res;
            u_check.expect_retire(w[15:12], res);
          end
          if (w[20]) begin
            f[3] = res[31];
            f[2] = (res == '0);
            if (arith) begin
              f[1] = c;
              f[0] = v;
            end
          end
        end
        pc = pc + 32'd4;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus tasks

  task automatic reset_core();
    nreset = 1'b0;
    repeat (2) @(negedge clk);
    nreset = 1'b1;
  endtask

  task automatic load_code();
    int k;
    for (k = 0; k < code_len; k++) begin
      @(negedge clk);
      imem_we   = 1'b1;
      imem_addr = 4'(k);
      imem_data = code[k];
    end
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  task automatic wait_drained(output logic drained);
    int n;
    n = 0;
    while (u_check.pending() != 0 && n < 300) begin
      @(negedge clk);
      n++;
    end
    drained = (u_check.pending() == 0);
    if (!drained) begin
      $display("timeout: %0d expected events never appeared", u_check.pending());
    end
  endtask

  initial begin
    int   row;
    logic drained;
    nreset    = 1'b0;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    timeouts  = 0;
    lcg_state = 32'ha504_5dda;
    build_table();
    reset_core();
    // stopped core stays quiet
    repeat (20) @(negedge clk);
    for (row = 0; row < num_rows && timeouts == 0; row++) begin
      fill_row(row);
      load_code();
      run_model();
      @(negedge clk);
      run = 1'b1;
      wait_drained(drained);
      if (drained) begin
        // halt loop where nothing more may retire
        repeat (40) @(negedge clk);
      end else begin
        timeouts++;
      end
      run = 1'b0;
      @(negedge clk);
      reset_core();
    end
    total = u_check.value_errors + u_check.extra_errors + DUT.u_assert.fail_count +
            timeouts;
    $display("errors: %0d wrong value, %0d unexpected event, %0d assertion, %0d timeout",
             u_check.value_errors, u_check.extra_errors, DUT.u_assert.fail_count,
             timeouts);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/arm_core_assert.sv */
`default_nettype none

module arm_core_assert (
  input wire       clk,
  input wire       nreset,
  input wire       run,
  input wire       imem_we,
  input wire       wb_valid,
  input wire [3:0] wb_reg,
  input wire       st_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // r15 is never written through the retire port
  no_pc_retire: assert property (@(posedge clk) disable iff (!nreset)
    wb_valid |-> (wb_reg != 4'd15))
    else begin
      fail_count++;
      $error("retire to r15");
    end

  // core stopped, nothing leaves it
  quiet_when_stopped: assert property (@(posedge clk) disable iff (!nreset)
    !run |-> (!wb_valid && !st_valid))
    else begin
      fail_count++;
      $error("retire or store while run is low");
    end

  no_load_while_running: assert property (@(posedge clk)
    imem_we |-> !run)
    else begin
      fail_count++;
      $error("code write while run is high");
    end

endmodule

bind arm_core arm_core_assert u_assert (
  .clk(clk), .nreset(nreset), .run(run), .imem_we(imem_we),
  .wb_valid(wb_valid), .wb_reg(wb_reg), .st_valid(st_valid)
);

`default_nettype wire

/* bench/arm_checker.sv */
`default_nettype none

module arm_checker (
  input wire        clk,
  input wire        wb_valid,
  input wire [3:0]  wb_reg,
  input wire [31:0] wb_data,
  input wire        st_valid,
  input wire [2:0]  st_addr,
  input wire [31:0] st_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // {reg, data} and {addr, data}
  logic [35:0] ret_q [$];
  logic [34:0] st_q [$];

  int value_errors = 0;
  int extra_errors = 0;

  task automatic expect_retire(input logic [3:0] n, input logic [31:0] d);
    ret_q.push_back({n, d});
  endtask

  task automatic expect_store(input logic [2:0] a, input logic [31:0] d);
    st_q.push_back({a, d});
  endtask

  function automatic int pending();
    return ret_q.size() + st_q.size();
  endfunction

  ////////////////////////////////////////////////////////////
  // compare, outputs settle well before the falling edge

  always @(negedge clk) begin
    logic [35:0] r;
    logic [34:0] s;
    if (wb_valid) begin
      if (ret_q.size() == 0) begin
        extra_errors++;
        $display("unexpected retire of r%0d = %h at %0t, nothing was expected",
                 wb_reg, wb_data, $time);
      end else begin
        r = ret_q.pop_front();
        if (r != {wb_reg, wb_data}) begin
          value_errors++;
          $display("Error at %0t: retire expected r%0d = %h, got r%0d = %h",
                   $time, r[35:32], r[31:0], wb_reg, wb_data);
        end
      end
    end
    if (st_valid) begin
      if (st_q.size() == 0) begin
        extra_errors++;
        $display("unexpected store to word %0d = %h at %0t, nothing was expected",
                 st_addr, st_data, $time);
      end else begin
        s = st_q.pop_front();
        if (s != {st_addr, st_data}) begin
          value_errors++;
          $display("Error at %0t: store expected [%0d] = %h, got [%0d] = %h",
                   $time, s[34:32], s[31:0], st_addr, st_data);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/arm_core.sv */
`default_nettype none

module arm_core (
  input  wire                               clk,
  input  wire                               nreset,
  input  wire                               run,
  input  wire                               imem_we,
  input  wire  [arm_pkg::code_addr_w-1:0]   imem_addr,
  input  wire  [arm_pkg::word_w-1:0]        imem_data,
  output wire                               wb_valid,
  output wire  arm_pkg::reg_num_t           wb_reg,
  output wire  [arm_pkg::word_w-1:0]        wb_data,
  output wire                               st_valid,
  output wire  [arm_pkg::data_addr_w-1:0]   st_addr,
  output wire  [arm_pkg::word_w-1:0]        st_data
);

  // fetch to decode
  wire                         f_valid;
  wire [arm_pkg::word_w-1:0]   f_inst;
  wire [arm_pkg::word_w-1:0]   f_pc;

  // decode to execute
  wire                         d_valid;
  wire arm_pkg::inst_t         d_inst;
  wire [arm_pkg::word_w-1:0]   d_pc;
  wire arm_pkg::reg_num_t      rs1;
  wire arm_pkg::reg_num_t      rs2;
  wire arm_pkg::reg_num_t      ws;
  wire                         we;
  wire                         op2_imm;
  wire                         mem_we;
  wire                         is_branch;
  wire [arm_pkg::word_w-1:0]   target;

  // flush path back from execute
  wire                         redirect;
  wire [arm_pkg::word_w-1:0]   redirect_pc;

  fetch_unit u_fetch (
    .clk(clk), .nreset(nreset), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .f_valid(f_valid), .f_inst(f_inst), .f_pc(f_pc)
  );

  decode_stage u_decode (
    .clk(clk), .nreset(nreset),
    .f_valid(f_valid), .f_inst(f_inst), .f_pc(f_pc), .redirect(redirect),
    .d_valid(d_valid), .d_inst(d_inst), .d_pc(d_pc),
    .rs1(rs1), .rs2(rs2), .ws(ws), .we(we),
    .op2_imm(op2_imm), .mem_we(mem_we), .is_branch(is_branch), .target(target)
  );

  execute_stage u_execute (
    .clk(clk), .nreset(nreset),
    .d_valid(d_valid), .d_inst(d_inst), .d_pc(d_pc),
    .rs1(rs1), .rs2(rs2), .ws(ws), .we(we),
    .op2_imm(op2_imm), .mem_we(mem_we), .is_branch(is_branch), .target(target),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
  );

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  wire                                clk,
  input  wire                                nreset,
  input  wire                                d_valid,
  input  wire  arm_pkg::inst_t               d_inst,
  input  wire  [arm_pkg::word_w-1:0]         d_pc,
  input  wire  arm_pkg::reg_num_t            rs1,
  input  wire  arm_pkg::reg_num_t            rs2,
  input  wire  arm_pkg::reg_num_t            ws,
  input  wire                                we,
  input  wire                                op2_imm,
  input  wire                                mem_we,
  input  wire                                is_branch,
  input  wire  [arm_pkg::word_w-1:0]         target,
  output logic                               redirect,
  output logic [arm_pkg::word_w-1:0]         redirect_pc,
  output logic                               wb_valid,
  output arm_pkg::reg_num_t                  wb_reg,
  output logic [arm_pkg::word_w-1:0]         wb_data,
  output logic                               st_valid,
  output logic [arm_pkg::data_addr_w-1:0]    st_addr,
  output logic [arm_pkg::word_w-1:0]         st_data
);

  // r0..r14, r15 is the pc
  logic [arm_pkg::word_w-1:0]     rf [15];
  logic [arm_pkg::word_w-1:0]     dmem [arm_pkg::data_words];
  logic [3:0]                     nzcv;

  logic [arm_pkg::word_w-1:0]     pc_plus8;
  logic [arm_pkg::word_w-1:0]     rd1;
  logic [arm_pkg::word_w-1:0]     rd2;
  logic [arm_pkg::word_w-1:0]     op2;
  logic                           is_bx;
  logic                           is_dp;
  logic                           is_link;
  logic                           cond_used;
  logic                           cond_pass;
  logic                           exec;
  logic                           sets_flags;
  logic [arm_pkg::word_w-1:0]     add_x;
  logic [arm_pkg::word_w-1:0]     add_y;
  logic                           add_cin;
  logic                           arith;
  logic [arm_pkg::word_w:0]       sum;
  logic [arm_pkg::word_w-1:0]     alu_res;
  logic [arm_pkg::word_w-1:0]     mem_addr;
  logic [arm_pkg::data_addr_w-1:0] mem_word;
  logic [arm_pkg::word_w-1:0]     wd;

  assign pc_plus8 = d_pc + 32'd8;
  assign rd1      = (rs1 == arm_pkg::reg_pc) ? pc_plus8 : rf[rs1];
  assign rd2      = (rs2 == arm_pkg::reg_pc) ? pc_plus8 : rf[rs2];
  // immediate is the low byte, no rotate
  assign op2      = op2_imm ? {24'b0, d_inst.dp.operand[7:0]} : rd2;

  assign is_bx     = is_branch && (d_inst.dp.cls != arm_pkg::cls_branch);
  assign is_dp     = (d_inst.dp.cls == arm_pkg::cls_data_proc) && !is_bx;
  assign is_link   = (d_inst.dp.cls == arm_pkg::cls_branch) && d_inst.br.link;
  assign cond_used = is_branch || (is_dp && d_inst.dp.s);
  assign exec      = d_valid && (!cond_used || cond_pass);
  assign sets_flags = exec && is_dp && d_inst.dp.s;

  ////////////////////////////////////////////////////////////
  // condition check

  always_comb begin
    case (d_inst.dp.cond)
      arm_pkg::cond_eq: cond_pass = nzcv[arm_pkg::flag_z];
      arm_pkg::cond_ne: cond_pass = !nzcv[arm_pkg::flag_z];
      arm_pkg::cond_cs: cond_pass = nzcv[arm_pkg::flag_c];
      arm_pkg::cond_cc: cond_pass = !nzcv[arm_pkg::flag_c];
      arm_pkg::cond_mi: cond_pass = nzcv[arm_pkg::flag_n];
      arm_pkg::cond_pl: cond_pass = !nzcv[arm_pkg::flag_n];
      arm_pkg::cond_vs: cond_pass = nzcv[arm_pkg::flag_v];
      arm_pkg::cond_vc: cond_pass = !nzcv[arm_pkg::flag_v];
      arm_pkg::cond_hi: cond_pass = nzcv[arm_pkg::flag_c] && !nzcv[arm_pkg::flag_z];
      arm_pkg::cond_ls: cond_pass = !nzcv[arm_pkg::flag_c] || nzcv[arm_pkg::flag_z];
      arm_pkg::cond_ge: cond_pass = nzcv[arm_pkg::flag_n] == nzcv[arm_pkg::flag_v];
      arm_pkg::cond_lt: cond_pass = nzcv[arm_pkg::flag_n] != nzcv[arm_pkg::flag_v];
      arm_pkg::cond_gt: cond_pass = !nzcv[arm_pkg::flag_z] &&
                                    (nzcv[arm_pkg::flag_n] == nzcv[arm_pkg::flag_v]);
      arm_pkg::cond_le: cond_pass = nzcv[arm_pkg::flag_z] ||
                                    (nzcv[arm_pkg::flag_n] != nzcv[arm_pkg::flag_v]);
      arm_pkg::cond_al: cond_pass = 1'b1;
      default:          cond_pass = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // alu

  // one adder, subtract as x + ~y + 1
  always_comb begin
    add_x   = rd1;
    add_y   = op2;
    add_cin = 1'b0;
    arith   = 1'b1;
    case (d_inst.dp.opcode)
      arm_pkg::op_sub, arm_pkg::op_cmp: begin
        add_y   = ~op2;
        add_cin = 1'b1;
      end
      arm_pkg::op_rsb: begin
        add_x   = op2;
        add_y   = ~rd1;
        add_cin = 1'b1;
      end
      arm_pkg::op_adc: add_cin = nzcv[arm_pkg::flag_c];
      arm_pkg::op_sbc: begin
        add_y   = ~op2;
        add_cin = nzcv[arm_pkg::flag_c];
      end
      arm_pkg::op_rsc: begin
        add_x   = op2;
        add_y   = ~rd1;
        add_cin = nzcv[arm_pkg::flag_c];
      end
      arm_pkg::op_add, arm_pkg::op_cmn: arith = 1'b1;
      default: arith = 1'b0;
    endcase
    sum = {1'b0, add_x} + {1'b0, add_y} + {32'b0, add_cin};
  end

  always_comb begin
    case (d_inst.dp.opcode)
      arm_pkg::op_and, arm_pkg::op_tst: alu_res = rd1 & op2;
      arm_pkg::op_eor, arm_pkg::op_teq: alu_res = rd1 ^ op2;
      arm_pkg::op_orr: alu_res = rd1 | op2;
      arm_pkg::op_mov: alu_res = op2;
      arm_pkg::op_bic: alu_res = rd1 & ~op2;
      arm_pkg::op_mvn: alu_res = ~op2;
      default:         alu_res = sum[arm_pkg::word_w-1:0];
    endcase
  end

  // logical ops keep C and V
  always_ff @(posedge clk) begin
    if (!nreset) begin
      nzcv <= '0;
    end else if (sets_flags) begin
      nzcv[arm_pkg::flag_n] <= alu_res[31];
      nzcv[arm_pkg::flag_z] <= (alu_res == '0);
      if (arith) begin
        nzcv[arm_pkg::flag_c] <= sum[32];
        nzcv[arm_pkg::flag_v] <= (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // memory, register write and redirect

  assign mem_addr = rd1 + {20'b0, d_inst.ls.offset};
  assign mem_word = mem_addr[arm_pkg::data_addr_w+1:2];

  always_comb begin
    if (is_link) begin
      wd = d_pc + 32'd4;
    end else if (d_inst.ls.cls == arm_pkg::cls_ldr_str) begin
      wd = dmem[mem_word];
    end else begin
      wd = alu_res;
    end
  end

  always_ff @(posedge clk) begin
    if (exec && we) begin
      rf[ws] <= wd;
    end
    if (exec && mem_we) begin
      dmem[mem_word] <= rd2;
    end
  end

  assign redirect    = exec && is_branch;
  // bx target is word aligned, low bits dropped
  assign redirect_pc = is_bx ? {rd1[31:2], 2'b00} : target;

  always_ff @(posedge clk) begin
    if (!nreset) begin
      wb_valid <= 1'b0;
      st_valid <= 1'b0;
    end else begin
      wb_valid <= exec && we;
      st_valid <= exec && mem_we;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= ws;
    wb_data <= wd;
    st_addr <= mem_word;
    st_data <= rd2;
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none

module decode_stage (
  input  wire                          clk,
  input  wire                          nreset,
  input  wire                          f_valid,
  input  wire  [arm_pkg::word_w-1:0]   f_inst,
  input  wire  [arm_pkg::word_w-1:0]   f_pc,
  input  wire                          redirect,
  output logic                         d_valid,
  output arm_pkg::inst_t               d_inst,
  output logic [arm_pkg::word_w-1:0]   d_pc,
  output arm_pkg::reg_num_t            rs1,
  output arm_pkg::reg_num_t            rs2,
  output arm_pkg::reg_num_t            ws,
  output logic                         we,
  output logic                         op2_imm,
  output logic                         mem_we,
  output logic                         is_branch,
  output logic [arm_pkg::word_w-1:0]   target
);

  arm_pkg::inst_t             fi;
  logic                       is_bx;
  logic                       is_dp;
  logic                       is_ls;
  logic                       is_br;
  arm_pkg::reg_num_t          ws_next;
  logic                       we_next;
  logic [arm_pkg::word_w-1:0] br_offset;

  assign fi        = f_inst;
  assign is_bx     = (f_inst[27:4] == arm_pkg::bx_pattern);
  assign is_dp     = (fi.dp.cls == arm_pkg::cls_data_proc) && !is_bx;
  assign is_ls     = (fi.ls.cls == arm_pkg::cls_ldr_str);
  assign is_br     = (fi.dp.cls == arm_pkg::cls_branch);
  assign br_offset = {{6{fi.br.offset[23]}}, fi.br.offset, 2'b00};

  // destination register and write enable
  always_comb begin
    ws_next = fi.dp.rd;
    we_next = 1'b0;
    if (is_br) begin
      ws_next = arm_pkg::reg_lr;
      we_next = fi.br.link;
    end else if (is_ls) begin
      we_next = fi.ls.l;
    end else if (is_dp) begin
      case (fi.dp.opcode)
        arm_pkg::op_tst, arm_pkg::op_teq, arm_pkg::op_cmp, arm_pkg::op_cmn: we_next = 1'b0;
        default: we_next = 1'b1;
      endcase
    end
    // no writes to the pc through the register file
    if (ws_next == arm_pkg::reg_pc) begin
      we_next = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!nreset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid && !redirect;
    end
  end

  ////////////////////////////////////////////////////////////
  // decode register payload

  always_ff @(posedge clk) begin
    d_inst    <= fi;
    d_pc      <= f_pc;
    // bx reads Rm on the first port
    rs1       <= is_bx ? f_inst[3:0] : fi.dp.rn;
    // store data is Rd, otherwise Rm
    rs2       <= is_ls ? fi.ls.rd : fi.dp.operand[3:0];
    ws        <= ws_next;
    we        <= we_next;
    op2_imm   <= is_dp && fi.dp.imm;
    mem_we    <= is_ls && !fi.ls.l;
    is_branch <= is_br || is_bx;
    target    <= f_pc + 32'd8 + br_offset;
  end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit (
  input  wire                               clk,
  input  wire                               nreset,
  input  wire                               run,
  input  wire                               imem_we,
  input  wire  [arm_pkg::code_addr_w-1:0]   imem_addr,
  input  wire  [arm_pkg::word_w-1:0]        imem_data,
  input  wire                               redirect,
  input  wire  [arm_pkg::word_w-1:0]        redirect_pc,
  output logic                              f_valid,
  output logic [arm_pkg::word_w-1:0]        f_inst,
  output logic [arm_pkg::word_w-1:0]        f_pc
);

  logic [arm_pkg::word_w-1:0] code_mem [arm_pkg::code_words];
  logic [arm_pkg::word_w-1:0] pc;

  // program load while the core is stopped
  always_ff @(posedge clk) begin
    if (imem_we && !run) begin
      code_mem[imem_addr] <= imem_data;
    end
  end

  // pc and fetch valid
  always_ff @(posedge clk) begin
    if (!nreset) begin
      pc      <= '0;
      f_valid <= 1'b0;
    end else if (redirect) begin
      // taken branch, fetched word is dropped
      pc      <= redirect_pc;
      f_valid <= 1'b0;
    end else if (run) begin
      pc      <= pc + 32'd4;
      f_valid <= 1'b1;
    end else begin
      f_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      f_inst <= code_mem[pc[arm_pkg::code_addr_w+1:2]];
      f_pc   <= pc;
    end
  end

endmodule

`default_nettype wire

/* verilog/arm_pkg.sv */
`default_nettype none

package arm_pkg;

  ////////////////////////////////////////////////////////////
  // sizes

  localparam int word_w      = 32;
  localparam int code_words  = 16;
  localparam int code_addr_w = 4;
  localparam int data_words  = 8;
  localparam int data_addr_w = 3;

  // register numbers, r15 reads as the pc
  typedef logic [3:0] reg_num_t;
  localparam reg_num_t reg_lr = 4'd14;
  localparam reg_num_t reg_pc = 4'd15;

  ////////////////////////////////////////////////////////////
  // field codes

  // 4'hf is not used and never passes
  typedef enum logic [3:0] {
    cond_eq = 4'h0,
    cond_ne = 4'h1,
    cond_cs = 4'h2,
    cond_cc = 4'h3,
    cond_mi = 4'h4,
    cond_pl = 4'h5,
    cond_vs = 4'h6,
    cond_vc = 4'h7,
    cond_hi = 4'h8,
    cond_ls = 4'h9,
    cond_ge = 4'ha,
    cond_lt = 4'hb,
    cond_gt = 4'hc,
    cond_le = 4'hd,
    cond_al = 4'he
  } cond_t;

  typedef enum logic [3:0] {
    op_and = 4'h0,
    op_eor = 4'h1,
    op_sub = 4'h2,
    op_rsb = 4'h3,
    op_add = 4'h4,
    op_adc = 4'h5,
    op_sbc = 4'h6,
    op_rsc = 4'h7,
    op_tst = 4'h8,
    op_teq = 4'h9,
    op_cmp = 4'ha,
    op_cmn = 4'hb,
    op_orr = 4'hc,
    op_mov = 4'hd,
    op_bic = 4'he,
    op_mvn = 4'hf
  } opcode_t;

  // instruction bits 27..26
  typedef enum logic [1:0] {
    cls_data_proc = 2'b00,
    cls_ldr_str   = 2'b01,
    cls_branch    = 2'b10
  } inst_class_t;

  // bits 27..4 of bx, Rm sits below
  localparam logic [23:0] bx_pattern = 24'h12_fff1;

  // positions inside nzcv
  localparam int flag_n = 3;
  localparam int flag_z = 2;
  localparam int flag_c = 1;
  localparam int flag_v = 0;

  ////////////////////////////////////////////////////////////
  // instruction views

  typedef struct packed {
    cond_t       cond;
    inst_class_t cls;
    logic        imm;
    opcode_t     opcode;
    logic        s;
    reg_num_t    rn;
    reg_num_t    rd;
    logic [11:0] operand;
  } dp_view_t;

  typedef struct packed {
    cond_t       cond;
    inst_class_t cls;
    logic        i;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    reg_num_t    rn;
    reg_num_t    rd;
    logic [11:0] offset;
  } ls_view_t;

  typedef struct packed {
    cond_t       cond;
    logic [2:0]  code;
    logic        link;
    logic [23:0] offset;
  } br_view_t;

  typedef union packed {
    dp_view_t dp;
    ls_view_t ls;
    br_view_t br;
  } inst_t;

endpackage

`default_nettype wire
